// File: hw/wr_bus_pkg.sv
package wr_bus_pkg;

    // bus geometry
    localparam int ADDR_WIDTH  = 32;
    localparam int NUM_MASTERS = 3;
    localparam int NUM_SLAVES  = 8;

    // granted master, 0..2
    typedef logic [1:0] master_idx_t;
    // target slave, 0..7 real, 8 is the decode-error sink
    typedef logic [3:0] slave_idx_t;

    localparam slave_idx_t DEFAULT_SLAVE = 4'd8;

    // write response codes
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // region tags, upper 16 address bits
    localparam logic [15:0] REGION_ROM   = 16'h0000;
    localparam logic [15:0] REGION_IM    = 16'h0001;
    localparam logic [15:0] REGION_DM    = 16'h0002;
    localparam logic [15:0] REGION_SCTRL = 16'h1000;
    localparam logic [15:0] REGION_WDT   = 16'h1001;
    localparam logic [15:0] REGION_EPU   = 16'h0010;
    localparam logic [15:0] REGION_DMA   = 16'h0003;
    // DRAM is the only region tagged by the top byte alone
    localparam logic [7:0]  REGION_DRAM  = 8'h20;

    // address to slave port, unmapped goes to the sink
    function automatic slave_idx_t decode_slave(input logic [ADDR_WIDTH-1:0] addr);
        logic [15:0] region;
        slave_idx_t  idx;
        region = addr[ADDR_WIDTH-1 -: 16];
        case (region)
            REGION_ROM:   idx = 4'd0;
            REGION_IM:    idx = 4'd1;
            REGION_DM:    idx = 4'd2;
            REGION_SCTRL: idx = 4'd3;
            REGION_WDT:   idx = 4'd4;
            REGION_EPU:   idx = 4'd6;
            REGION_DMA:   idx = 4'd7;
            default: begin
                // 0x20xx_xxxx, any lower byte of the tag
                if (addr[ADDR_WIDTH-1 -: 8] == REGION_DRAM) begin
                    idx = 4'd5;
                end else begin
                    idx = DEFAULT_SLAVE;
                end
            end
        endcase
        return idx;
    endfunction

endpackage

// File: hw/write_arbiter.sv
module write_arbiter (
    input  logic                               ACLK,
    input  logic                               ARESETn,
    // raw AW requests from every master
    input  logic                               aw_valid [wr_bus_pkg::NUM_MASTERS],
    input  logic [wr_bus_pkg::ADDR_WIDTH-1:0]  aw_addr  [wr_bus_pkg::NUM_MASTERS],
    // granted W channel as seen after the mux
    input  logic                               w_valid,
    input  logic                               w_ready,
    input  logic                               w_last,
    // B still owed to the last master
    input  logic                               resp_pending,
    output logic                               grant_valid,
    output wr_bus_pkg::master_idx_t            grant_master,
    output wr_bus_pkg::slave_idx_t             grant_slave,
    output logic                               w_done
);

    // one state per owning master
    typedef enum logic [1:0] {
        IDLE,
        M0,
        M1,
        M2
    } state_t;

    state_t                  state;
    logic                    req_any;
    wr_bus_pkg::master_idx_t req_master;

    // fixed priority, M2 first
    always_comb begin
        req_any    = aw_valid[2] || aw_valid[1] || aw_valid[0];
        req_master = 2'd0;
        if (aw_valid[2]) begin
            req_master = 2'd2;
        end else if (aw_valid[1]) begin
            req_master = 2'd1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state       <= IDLE;
            grant_slave <= wr_bus_pkg::DEFAULT_SLAVE;
        end else begin
            case (state)
                IDLE: begin
                    // wait out the previous response before a new grant
                    if (req_any && !resp_pending) begin
                        grant_slave <= wr_bus_pkg::decode_slave(aw_addr[req_master]);
                        case (req_master)
                            2'd2:    state <= M2;
                            2'd1:    state <= M1;
                            default: state <= M0;
                        endcase
                    end
                end
                default: begin
                    // route held until the last beat is taken
                    if (w_done) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    assign grant_valid = (state != IDLE);

    always_comb begin
        case (state)
            M1:      grant_master = 2'd1;
            M2:      grant_master = 2'd2;
            default: grant_master = 2'd0;
        endcase
    end

    // final beat accepted by the routed slave
    assign w_done = grant_valid && w_valid && w_ready && w_last;

    // route must not move under an active burst
    a_grant_stable: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        grant_valid && $past(grant_valid) |-> $stable(grant_master) && $stable(grant_slave)
    ) else $error("grant route changed while grant_valid high");

endmodule

// File: hw/channel_mux.sv
module channel_mux #(
    parameter type payload_t = logic
) (
    input  logic                     grant_valid,
    input  wr_bus_pkg::master_idx_t  grant_master,
    input  wr_bus_pkg::slave_idx_t   grant_slave,
    // master side
    input  logic                     src_valid   [wr_bus_pkg::NUM_MASTERS],
    input  payload_t                 src_payload [wr_bus_pkg::NUM_MASTERS],
    output logic                     src_ready   [wr_bus_pkg::NUM_MASTERS],
    // slave side, last entry is the default slave
    input  logic                     dst_ready   [wr_bus_pkg::NUM_SLAVES+1],
    output logic                     dst_valid   [wr_bus_pkg::NUM_SLAVES+1],
    output payload_t                 dst_payload [wr_bus_pkg::NUM_SLAVES+1],
    // the granted pair
    output logic                     sel_valid,
    output logic                     sel_ready,
    output payload_t                 sel_payload
);

    logic [wr_bus_pkg::NUM_SLAVES:0] dst_valid_vec;

    always_comb begin
        sel_payload = src_payload[grant_master];
        sel_valid   = grant_valid && src_valid[grant_master];
        sel_ready   = grant_valid && dst_ready[grant_slave];
        // ready only back to the owner
        for (int m = 0; m < wr_bus_pkg::NUM_MASTERS; m++) begin
            src_ready[m] = sel_ready && (grant_master == wr_bus_pkg::master_idx_t'(m));
        end
        // valid only to the routed target, payload goes everywhere
        for (int s = 0; s <= wr_bus_pkg::NUM_SLAVES; s++) begin
            dst_valid_vec[s] = sel_valid && (grant_slave == wr_bus_pkg::slave_idx_t'(s));
            dst_valid[s]     = dst_valid_vec[s];
            dst_payload[s]   = sel_payload;
        end
    end

    // never two targets at once
    always_comb begin
        a_dst_onehot: assert ($onehot0(dst_valid_vec))
            else $error("more than one dst_valid high: %h", dst_valid_vec);
    end

endmodule

// File: hw/resp_router.sv
module resp_router #(
    parameter int ID_WIDTH = 4
) (
    input  logic                     ACLK,
    input  logic                     ARESETn,
    input  logic                     w_done,
    input  wr_bus_pkg::master_idx_t  grant_master,
    input  wr_bus_pkg::slave_idx_t   grant_slave,
    input  logic [ID_WIDTH-1:0]      aw_id,
    output logic                     resp_pending,
    // default slave, takes everything
    output logic                     dflt_aw_ready,
    output logic                     dflt_w_ready,
    // slave B
    input  logic                     s_b_valid [wr_bus_pkg::NUM_SLAVES],
    input  wr_bus_pkg::resp_t        s_b_resp  [wr_bus_pkg::NUM_SLAVES],
    input  logic [ID_WIDTH-1:0]      s_b_id    [wr_bus_pkg::NUM_SLAVES],
    output logic                     s_b_ready [wr_bus_pkg::NUM_SLAVES],
    // master B
    input  logic                     m_b_ready [wr_bus_pkg::NUM_MASTERS],
    output logic                     m_b_valid [wr_bus_pkg::NUM_MASTERS],
    output wr_bus_pkg::resp_t        m_b_resp  [wr_bus_pkg::NUM_MASTERS],
    output logic [ID_WIDTH-1:0]      m_b_id    [wr_bus_pkg::NUM_MASTERS]
);

    wr_bus_pkg::master_idx_t route_master;
    wr_bus_pkg::slave_idx_t  route_slave;
    logic [ID_WIDTH-1:0]     route_id;
    logic                    dflt_b_valid;
    logic                    is_dflt;
    logic                    b_valid;
    logic                    b_ready;
    wr_bus_pkg::resp_t       b_resp;
    logic [ID_WIDTH-1:0]     b_id;

    assign dflt_aw_ready = 1'b1;
    assign dflt_w_ready  = 1'b1;

    // route snapshot at the last W beat
    always_ff @(posedge ACLK) begin
        if (w_done) begin
            route_master <= grant_master;
            route_slave  <= grant_slave;
            route_id     <= aw_id;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            resp_pending <= 1'b0;
            dflt_b_valid <= 1'b0;
        end else if (w_done) begin
            resp_pending <= 1'b1;
            // decode error answered on the next cycle
            dflt_b_valid <= (grant_slave == wr_bus_pkg::DEFAULT_SLAVE);
        end else if (resp_pending && b_valid && b_ready) begin
            resp_pending <= 1'b0;
            dflt_b_valid <= 1'b0;
        end
    end

    always_comb begin
        is_dflt = (route_slave == wr_bus_pkg::DEFAULT_SLAVE);
        b_valid = is_dflt ? dflt_b_valid : s_b_valid[route_slave[2:0]];
        b_resp  = is_dflt ? wr_bus_pkg::RESP_DECERR : s_b_resp[route_slave[2:0]];
        b_id    = is_dflt ? route_id : s_b_id[route_slave[2:0]];
        b_ready = m_b_ready[route_master];
        for (int s = 0; s < wr_bus_pkg::NUM_SLAVES; s++) begin
            s_b_ready[s] = resp_pending && !is_dflt && b_ready
                        && (route_slave == wr_bus_pkg::slave_idx_t'(s));
        end
        for (int m = 0; m < wr_bus_pkg::NUM_MASTERS; m++) begin
            m_b_valid[m] = resp_pending && b_valid
                        && (route_master == wr_bus_pkg::master_idx_t'(m));
            m_b_resp[m]  = b_resp;
            m_b_id[m]    = b_id;
        end
    end

    // no B reaches a master outside a pending response
    a_b_needs_pending: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        (m_b_valid[0] || m_b_valid[1] || m_b_valid[2]) |-> resp_pending
    ) else $error("m_b_valid high with no response pending");

    // arbiter must hold off a new burst until B is done
    a_single_outstanding: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        w_done |-> !resp_pending
    ) else $error("w_done while a response is still pending");

endmodule

// File: hw/write_interconnect.sv
module write_interconnect #(
    parameter int DATA_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  logic                               ACLK,
    input  logic                               ARESETn,
    // masters
    input  logic                               m_aw_valid [wr_bus_pkg::NUM_MASTERS],
    input  logic [wr_bus_pkg::ADDR_WIDTH-1:0]  m_aw_addr  [wr_bus_pkg::NUM_MASTERS],
    input  logic [ID_WIDTH-1:0]                m_aw_id    [wr_bus_pkg::NUM_MASTERS],
    output logic                               m_aw_ready [wr_bus_pkg::NUM_MASTERS],
    input  logic                               m_w_valid  [wr_bus_pkg::NUM_MASTERS],
    input  logic [DATA_WIDTH-1:0]              m_w_data   [wr_bus_pkg::NUM_MASTERS],
    input  logic                               m_w_last   [wr_bus_pkg::NUM_MASTERS],
    output logic                               m_w_ready  [wr_bus_pkg::NUM_MASTERS],
    output logic                               m_b_valid  [wr_bus_pkg::NUM_MASTERS],
    output wr_bus_pkg::resp_t                  m_b_resp   [wr_bus_pkg::NUM_MASTERS],
    output logic [ID_WIDTH-1:0]                m_b_id     [wr_bus_pkg::NUM_MASTERS],
    input  logic                               m_b_ready  [wr_bus_pkg::NUM_MASTERS],
    // slaves
    output logic                               s_aw_valid [wr_bus_pkg::NUM_SLAVES],
    output logic [wr_bus_pkg::ADDR_WIDTH-1:0]  s_aw_addr  [wr_bus_pkg::NUM_SLAVES],
    output logic [ID_WIDTH-1:0]                s_aw_id    [wr_bus_pkg::NUM_SLAVES],
    input  logic                               s_aw_ready [wr_bus_pkg::NUM_SLAVES],
    output logic                               s_w_valid  [wr_bus_pkg::NUM_SLAVES],
    output logic [DATA_WIDTH-1:0]              s_w_data   [wr_bus_pkg::NUM_SLAVES],
    output logic                               s_w_last   [wr_bus_pkg::NUM_SLAVES],
    input  logic                               s_w_ready  [wr_bus_pkg::NUM_SLAVES],
    input  logic                               s_b_valid  [wr_bus_pkg::NUM_SLAVES],
    input  wr_bus_pkg::resp_t                  s_b_resp   [wr_bus_pkg::NUM_SLAVES],
    input  logic [ID_WIDTH-1:0]                s_b_id     [wr_bus_pkg::NUM_SLAVES],
    output logic                               s_b_ready  [wr_bus_pkg::NUM_SLAVES]
);

    typedef struct packed {
        logic [wr_bus_pkg::ADDR_WIDTH-1:0] addr;
        logic [ID_WIDTH-1:0]               id;
    } aw_payload_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } w_payload_t;

    logic                    grant_valid;
    wr_bus_pkg::master_idx_t grant_master;
    wr_bus_pkg::slave_idx_t  grant_slave;
    logic                    w_done;
    logic                    resp_pending;
    logic                    dflt_aw_ready;
    logic                    dflt_w_ready;

    aw_payload_t m_aw_payload   [wr_bus_pkg::NUM_MASTERS];
    aw_payload_t aw_dst_payload [wr_bus_pkg::NUM_SLAVES+1];
    logic        aw_dst_valid   [wr_bus_pkg::NUM_SLAVES+1];
    logic        aw_dst_ready   [wr_bus_pkg::NUM_SLAVES+1];
    aw_payload_t aw_sel_payload;

    w_payload_t  m_w_payload    [wr_bus_pkg::NUM_MASTERS];
    w_payload_t  w_dst_payload  [wr_bus_pkg::NUM_SLAVES+1];
    logic        w_dst_valid    [wr_bus_pkg::NUM_SLAVES+1];
    logic        w_dst_ready    [wr_bus_pkg::NUM_SLAVES+1];
    logic        w_sel_valid;
    logic        w_sel_ready;
    w_payload_t  w_sel_payload;

    // bundle master fields into mux payloads
    for (genvar m = 0; m < wr_bus_pkg::NUM_MASTERS; m++) begin : g_master
        assign m_aw_payload[m] = '{addr: m_aw_addr[m], id: m_aw_id[m]};
        assign m_w_payload[m]  = '{data: m_w_data[m], last: m_w_last[m]};
    end

    // unbundle toward the real slaves
    for (genvar s = 0; s < wr_bus_pkg::NUM_SLAVES; s++) begin : g_slave
        assign s_aw_valid[s]   = aw_dst_valid[s];
        assign s_aw_addr[s]    = aw_dst_payload[s].addr;
        assign s_aw_id[s]      = aw_dst_payload[s].id;
        assign s_w_valid[s]    = w_dst_valid[s];
        assign s_w_data[s]     = w_dst_payload[s].data;
        assign s_w_last[s]     = w_dst_payload[s].last;
        assign aw_dst_ready[s] = s_aw_ready[s];
        assign w_dst_ready[s]  = s_w_ready[s];
    end

    // ninth target is the decode-error sink
    assign aw_dst_ready[wr_bus_pkg::NUM_SLAVES] = dflt_aw_ready;
    assign w_dst_ready[wr_bus_pkg::NUM_SLAVES]  = dflt_w_ready;

    write_arbiter u_arbiter (
        .ACLK         (ACLK),
        .ARESETn      (ARESETn),
        .aw_valid     (m_aw_valid),
        .aw_addr      (m_aw_addr),
        .w_valid      (w_sel_valid),
        .w_ready      (w_sel_ready),
        .w_last       (w_sel_payload.last),
        .resp_pending (resp_pending),
        .grant_valid  (grant_valid),
        .grant_master (grant_master),
        .grant_slave  (grant_slave),
        .w_done       (w_done)
    );

    channel_mux #(.payload_t(aw_payload_t)) u_aw_mux (
        .grant_valid  (grant_valid),
        .grant_master (grant_master),
        .grant_slave  (grant_slave),
        .src_valid    (m_aw_valid),
        .src_payload  (m_aw_payload),
        .src_ready    (m_aw_ready),
        .dst_ready    (aw_dst_ready),
        .dst_valid    (aw_dst_valid),
        .dst_payload  (aw_dst_payload),
        .sel_valid    (),
        .sel_ready    (),
        .sel_payload  (aw_sel_payload)
    );

    channel_mux #(.payload_t(w_payload_t)) u_w_mux (
        .grant_valid  (grant_valid),
        .grant_master (grant_master),
        .grant_slave  (grant_slave),
        .src_valid    (m_w_valid),
        .src_payload  (m_w_payload),
        .src_ready    (m_w_ready),
        .dst_ready    (w_dst_ready),
        .dst_valid    (w_dst_valid),
        .dst_payload  (w_dst_payload),
        .sel_valid    (w_sel_valid),
        .sel_ready    (w_sel_ready),
        .sel_payload  (w_sel_payload)
    );

    resp_router #(.ID_WIDTH(ID_WIDTH)) u_resp_router (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .w_done        (w_done),
        .grant_master  (grant_master),
        .grant_slave   (grant_slave),
        .aw_id         (aw_sel_payload.id),
        .resp_pending  (resp_pending),
        .dflt_aw_ready (dflt_aw_ready),
        .dflt_w_ready  (dflt_w_ready),
        .s_b_valid     (s_b_valid),
        .s_b_resp      (s_b_resp),
        .s_b_id        (s_b_id),
        .s_b_ready     (s_b_ready),
        .m_b_ready     (m_b_ready),
        .m_b_valid     (m_b_valid),
        .m_b_resp      (m_b_resp),
        .m_b_id        (m_b_id)
    );

endmodule

// File: verification/tb_write_tasks.svh
`ifndef TB_WRITE_TASKS_SVH
`define TB_WRITE_TASKS_SVH

// prints the reason, then the fail message, and stops
task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
endtask

task automatic check_resp(input string name, input wr_bus_pkg::resp_t got,
                          input wr_bus_pkg::resp_t exp);
    if (got !== exp) stop_on_error($sformatf("[ERROR] %s got %h exp %h", name, got, exp));
endtask

task automatic check_slave(input string name, input wr_bus_pkg::slave_idx_t got,
                           input wr_bus_pkg::slave_idx_t exp);
    if (got !== exp) stop_on_error($sformatf("[ERROR] %s got %h exp %h", name, got, exp));
endtask

task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                          input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) stop_on_error($sformatf("[ERROR] %s got %h exp %h", name, got, exp));
endtask

task automatic check_addr(input string name, input logic [wr_bus_pkg::ADDR_WIDTH-1:0] got,
                          input logic [wr_bus_pkg::ADDR_WIDTH-1:0] exp);
    if (got !== exp) stop_on_error($sformatf("[ERROR] %s got %h exp %h", name, got, exp));
endtask

task automatic check_id(input string name, input logic [ID_WIDTH-1:0] got,
                        input logic [ID_WIDTH-1:0] exp);
    if (got !== exp) stop_on_error($sformatf("[ERROR] %s got %h exp %h", name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) stop_on_error($sformatf("[ERROR] %s got %h exp %h", name, got, exp));
endtask

// bounded waits, each returns at a negedge with the condition true
task automatic wait_aw_ready(input int m);
    int n;
    for (n = 0; n < 200; n++) begin
        @(negedge ACLK);
        if (m_aw_ready[m]) break;
    end
    if (n == 200) stop_on_error($sformatf("timed out waiting for aw_ready of master %0d", m));
endtask

task automatic wait_w_ready(input int m);
    int n;
    for (n = 0; n < 200; n++) begin
        @(negedge ACLK);
        if (m_w_ready[m]) break;
    end
    if (n == 200) stop_on_error($sformatf("timed out waiting for w_ready of master %0d", m));
endtask

task automatic wait_b_valid(input int m);
    int n;
    for (n = 0; n < 200; n++) begin
        @(negedge ACLK);
        if (m_b_valid[m]) break;
    end
    if (n == 200) stop_on_error($sformatf("timed out waiting for b_valid of master %0d", m));
endtask

task automatic wait_aw_taken(input int m);
    int n;
    for (n = 0; n < 200; n++) begin
        if (aw_cycle[m] >= 0) break;
        @(posedge ACLK);
        #2;
    end
    if (n == 200) stop_on_error($sformatf("master %0d never had its AW accepted", m));
endtask

task automatic clear_records();
    rec_aw_slave.delete();
    rec_aw_addr.delete();
    rec_aw_id.delete();
    rec_w_slave.delete();
    rec_w_data.delete();
    rec_w_last.delete();
    rec_b_slave.delete();
    for (int m = 0; m < NM; m++) begin
        aw_cycle[m] = -1;
        b_cycle[m]  = -1;
    end
endtask

// full write from one master, entered 2 ns after a rising edge
task automatic write_txn(input int m, input logic [31:0] addr, input logic [ID_WIDTH-1:0] id,
                         input int nbeats, input logic [DATA_WIDTH-1:0] beats [4],
                         input wr_bus_pkg::resp_t exp_resp);
    m_aw_valid[m] = 1'b1;
    m_aw_addr[m]  = addr;
    m_aw_id[m]    = id;
    wait_aw_ready(m);
    @(posedge ACLK);
    #2;
    // addr and id stay on the bus, only valid drops
    m_aw_valid[m] = 1'b0;
    aw_cycle[m]   = cycle;
    for (int i = 0; i < nbeats; i++) begin
        m_w_valid[m] = 1'b1;
        m_w_data[m]  = beats[i];
        m_w_last[m]  = (i == nbeats - 1);
        wait_w_ready(m);
        @(posedge ACLK);
        #2;
    end
    m_w_valid[m] = 1'b0;
    m_w_last[m]  = 1'b0;
    m_b_ready[m] = 1'b1;
    wait_b_valid(m);
    check_resp("m_b_resp", m_b_resp[m], exp_resp);
    check_id("m_b_id", m_b_id[m], id);
    // B goes to the issuing master only
    for (int o = 0; o < NM; o++) begin
        if (o != m) check_flag("m_b_valid", m_b_valid[o], 1'b0);
    end
    @(posedge ACLK);
    #2;
    m_b_ready[m] = 1'b0;
    b_cycle[m]   = cycle;
endtask

task automatic test_reset_state();
    for (int s = 0; s < NS; s++) begin
        check_flag("s_aw_valid", s_aw_valid[s], 1'b0);
        check_flag("s_w_valid", s_w_valid[s], 1'b0);
    end
    for (int m = 0; m < NM; m++) begin
        check_flag("m_b_valid", m_b_valid[m], 1'b0);
        check_flag("m_aw_ready", m_aw_ready[m], 1'b0);
        check_flag("m_w_ready", m_w_ready[m], 1'b0);
    end
    // requests raised during reset come down before the first edge
    for (int m = 0; m < NM; m++) begin
        m_aw_valid[m] = 1'b0;
        m_w_valid[m]  = 1'b0;
    end
endtask

task automatic test_region_routing();
    logic [DATA_WIDTH-1:0] beats [4];
    logic [ID_WIDTH-1:0]   id;
    for (int m = 0; m < NM; m++) begin
        for (int r = 0; r < NS; r++) begin
            clear_records();
            beats[0] = $urandom;
            id = ID_WIDTH'(m * NS + r);
            check_slave("decode_slave", wr_bus_pkg::decode_slave(REGION_ADDR[r]),
                        wr_bus_pkg::slave_idx_t'(r));
            write_txn(m, REGION_ADDR[r], id, 1, beats, wr_bus_pkg::RESP_OKAY);
            if (rec_aw_slave.size() != 1 || rec_w_slave.size() != 1)
                stop_on_error($sformatf("region %0d did not see exactly one AW and W", r));
            check_slave("s_aw_valid index", rec_aw_slave[0], wr_bus_pkg::slave_idx_t'(r));
            check_addr("s_aw_addr", rec_aw_addr[0], REGION_ADDR[r]);
            check_id("s_aw_id", rec_aw_id[0], id);
            check_slave("s_w_valid index", rec_w_slave[0], wr_bus_pkg::slave_idx_t'(r));
            check_data("s_w_data", rec_w_data[0], beats[0]);
            check_flag("s_w_last", rec_w_last[0], 1'b1);
            if (rec_b_slave.size() != 1)
                stop_on_error($sformatf("slave %0d did not see exactly one B handshake", r));
            check_slave("s_b_ready index", rec_b_slave[0], wr_bus_pkg::slave_idx_t'(r));
        end
    end
endtask

task automatic test_unmapped();
    logic [DATA_WIDTH-1:0] beats [4];
    clear_records();
    beats[0] = $urandom;
    beats[1] = $urandom;
    write_txn(1, 32'h4000_1000, 4'ha, 2, beats, wr_bus_pkg::RESP_DECERR);
    if (rec_aw_slave.size() != 0 || rec_w_slave.size() != 0 || rec_b_slave.size() != 0)
        stop_on_error("an unmapped write reached a real slave");
endtask

task automatic test_priority();
    logic [DATA_WIDTH-1:0] beats [4];
    clear_records();
    beats[0] = $urandom;
    // all three requests rise in the same cycle
    fork
        write_txn(0, 32'h4000_0000, 4'h1, 1, beats, wr_bus_pkg::RESP_DECERR);
        write_txn(1, 32'h2000_0010, 4'h2, 1, beats, wr_bus_pkg::RESP_OKAY);
        write_txn(2, 32'h0002_0010, 4'h3, 1, beats, wr_bus_pkg::RESP_OKAY);
    join
    if (!(b_cycle[2] < b_cycle[1] && b_cycle[1] < b_cycle[0]))
        stop_on_error("simultaneous requests were not served as M2, M1, M0");
endtask

task automatic test_burst();
    logic [DATA_WIDTH-1:0] beats [4];
    clear_records();
    for (int i = 0; i < 4; i++) beats[i] = $urandom;
    write_txn(0, 32'h2011_0000, 4'h7, 4, beats, wr_bus_pkg::RESP_OKAY);
    if (rec_w_data.size() != 4) stop_on_error("burst did not deliver four beats");
    for (int i = 0; i < 4; i++) begin
        check_slave("s_w_valid index", rec_w_slave[i], 4'd5);
        check_data("s_w_data", rec_w_data[i], beats[i]);
        check_flag("s_w_last", rec_w_last[i], i == 3);
    end
endtask

task automatic test_blocking();
    logic [DATA_WIDTH-1:0] beats [4];
    clear_records();
    beats[0] = $urandom;
    beats[1] = $urandom;
    fork
        write_txn(0, 32'h0001_0200, 4'h4, 2, beats, wr_bus_pkg::RESP_OKAY);
        begin
            // second request rises once the first one owns the bus
            wait_aw_taken(0);
            write_txn(1, 32'h1001_0008, 4'h5, 1, beats, wr_bus_pkg::RESP_OKAY);
        end
    join
    if (aw_cycle[1] <= b_cycle[0])
        stop_on_error("second master got aw_ready before the first B completed");
endtask

`endif

// File: verification/tb_write_interconnect.sv
module tb_write_interconnect;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 4;
    localparam int NM         = wr_bus_pkg::NUM_MASTERS;
    localparam int NS         = wr_bus_pkg::NUM_SLAVES;

    // one probe address per region, in slave index order
    localparam logic [31:0] REGION_ADDR [NS] = '{
        32'h0000_0100, 32'h0001_0040, 32'h0002_0080, 32'h1000_0010,
        32'h1001_0004, 32'h20ab_0000, 32'h0010_0020, 32'h0003_0008
    };

    logic                              ACLK;
    logic                              ARESETn;
    logic                              m_aw_valid [NM];
    logic [wr_bus_pkg::ADDR_WIDTH-1:0] m_aw_addr  [NM];
    logic [ID_WIDTH-1:0]               m_aw_id    [NM];
    logic                              m_aw_ready [NM];
    logic                              m_w_valid  [NM];
    logic [DATA_WIDTH-1:0]             m_w_data   [NM];
    logic                              m_w_last   [NM];
    logic                              m_w_ready  [NM];
    logic                              m_b_valid  [NM];
    wr_bus_pkg::resp_t                 m_b_resp   [NM];
    logic [ID_WIDTH-1:0]               m_b_id     [NM];
    logic                              m_b_ready  [NM];
    logic                              s_aw_valid [NS];
    logic [wr_bus_pkg::ADDR_WIDTH-1:0] s_aw_addr  [NS];
    logic [ID_WIDTH-1:0]               s_aw_id    [NS];
    logic                              s_aw_ready [NS];
    logic                              s_w_valid  [NS];
    logic [DATA_WIDTH-1:0]             s_w_data   [NS];
    logic                              s_w_last   [NS];
    logic                              s_w_ready  [NS];
    logic                              s_b_valid  [NS];
    wr_bus_pkg::resp_t                 s_b_resp   [NS];
    logic [ID_WIDTH-1:0]               s_b_id     [NS];
    logic                              s_b_ready  [NS];

    // cycle stamps of AW and B handshakes per master
    int cycle;
    int aw_cycle [NM];
    int b_cycle  [NM];

    // what the slave models saw
    wr_bus_pkg::slave_idx_t            rec_aw_slave [$];
    logic [wr_bus_pkg::ADDR_WIDTH-1:0] rec_aw_addr  [$];
    logic [ID_WIDTH-1:0]               rec_aw_id    [$];
    wr_bus_pkg::slave_idx_t            rec_w_slave  [$];
    logic [DATA_WIDTH-1:0]             rec_w_data   [$];
    logic                              rec_w_last   [$];
    wr_bus_pkg::slave_idx_t            rec_b_slave  [$];

    // slave B state
    int                  b_wait   [NS];
    logic                b_clear  [NS];
    logic [ID_WIDTH-1:0] slave_id [NS];

    write_interconnect #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) DUT (.*);

    initial ACLK = 1'b0;
    always #10 ACLK = ~ACLK;

    always @(posedge ACLK) cycle <= cycle + 1;

    `include "tb_write_tasks.svh"

    // slave models: sample at negedge, drive 2 ns after posedge
    initial begin
        for (int s = 0; s < NS; s++) begin
            s_aw_ready[s] = 1'b0;
            s_w_ready[s]  = 1'b0;
            s_b_valid[s]  = 1'b0;
            s_b_resp[s]   = wr_bus_pkg::RESP_OKAY;
            s_b_id[s]     = '0;
            b_wait[s]     = -1;
            b_clear[s]    = 1'b0;
            slave_id[s]   = '0;
        end
        forever begin
            @(negedge ACLK);
            for (int s = 0; s < NS; s++) begin
                if (ARESETn && s_aw_valid[s] && s_aw_ready[s]) begin
                    rec_aw_slave.push_back(wr_bus_pkg::slave_idx_t'(s));
                    rec_aw_addr.push_back(s_aw_addr[s]);
                    rec_aw_id.push_back(s_aw_id[s]);
                    slave_id[s] = s_aw_id[s];
                end
                if (ARESETn && s_w_valid[s] && s_w_ready[s]) begin
                    rec_w_slave.push_back(wr_bus_pkg::slave_idx_t'(s));
                    rec_w_data.push_back(s_w_data[s]);
                    rec_w_last.push_back(s_w_last[s]);
                    // response after a random delay
                    if (s_w_last[s]) b_wait[s] = $urandom % 6;
                end
                if (ARESETn && s_b_valid[s] && s_b_ready[s]) begin
                    rec_b_slave.push_back(wr_bus_pkg::slave_idx_t'(s));
                    b_clear[s] = 1'b1;
                end
            end
            @(posedge ACLK);
            #2;
            for (int s = 0; s < NS; s++) begin
                // random back-pressure
                s_aw_ready[s] = ($urandom % 4) != 0;
                s_w_ready[s]  = ($urandom % 2) != 0;
                if (b_clear[s]) begin
                    s_b_valid[s] = 1'b0;
                    b_clear[s]   = 1'b0;
                end else if (b_wait[s] == 0) begin
                    s_b_valid[s] = 1'b1;
                    s_b_resp[s]  = wr_bus_pkg::RESP_OKAY;
                    s_b_id[s]    = slave_id[s];
                    b_wait[s]    = -1;
                end else if (b_wait[s] > 0) begin
                    b_wait[s] = b_wait[s] - 1;
                end
            end
        end
    end

    initial begin
        void'($urandom(65981));
        cycle   = 0;
        ARESETn = 1'b0;
        for (int m = 0; m < NM; m++) begin
            // requests held through reset
            m_aw_valid[m] = 1'b1;
            m_aw_addr[m]  = '0;
            m_aw_id[m]    = '0;
            m_w_valid[m]  = 1'b1;
            m_w_data[m]   = '0;
            m_w_last[m]   = 1'b0;
            m_b_ready[m]  = 1'b0;
        end
        repeat (4) @(posedge ACLK);
        #2;
        ARESETn = 1'b1;
        test_reset_state();
        test_region_routing();
        test_unmapped();
        test_priority();
        test_burst();
        test_blocking();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: write_interconnect.f
+incdir+verification
hw/wr_bus_pkg.sv
hw/write_arbiter.sv
hw/channel_mux.sv
hw/resp_router.sv
hw/write_interconnect.sv
verification/tb_write_interconnect.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the write interconnect testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module tb_write_interconnect -f write_interconnect.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }
